// File: Bender.yml
package:
  name: fetch_subsys

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fetch_pkg.sv
      - verilog/irq_debug_merge.sv
      - verilog/fetch_unit.sv
      - verilog/fetch_retire.sv
      - verilog/fetch_subsys_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/fetch_tb.sv

// File: filelist.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/irq_debug_merge.sv
verilog/fetch_unit.sv
verilog/fetch_retire.sv
verilog/fetch_subsys_top.sv
verification/fetch_tb.sv

// File: verification/fetch_tb.sv
//----------------------------------------------------------
// Directed testbench of the fetch subsystem with an OBI memory
// responder, a trace scoreboard and a cycle limit
//----------------------------------------------------------

`timescale 1ns/1ps

`include "fetch_params.svh"

module fetch_tb import fetch_pkg::*; ();

  // Well above the total length of all tests
  localparam int unsigned MAX_CYCLES = 2000;
  localparam word_t       DATA_KEY   = 32'hA5C3_0F96;

  logic       clk_i           = 1'b0;
  logic       rst_n_i         = 1'b0;
  logic       fetch_enable_i  = 1'b0;
  irq_vec_t   irq_ext_i       = '0;
  irq_vec_t   irq_vp_i        = '0;
  logic       debug_req_ext_i = 1'b0;
  logic       debug_req_vp_i  = 1'b0;
  logic       instr_gnt_i     = 1'b0;
  logic       instr_rvalid_i  = 1'b0;
  word_t      instr_rdata_i   = '0;
  logic       instr_req_o;
  addr_t      instr_addr_o;
  logic       instr_we_o;
  logic [3:0] instr_be_o;
  logic       irq_ack_o;
  irq_id_t    irq_id_o;
  logic       debug_mode_o;
  trace_t     trace_o;

  // Scoreboard of expected records in fetch order
  trace_t      exp_q[$];
  // One step below boot so the first sequential step lands on it
  addr_t       last_addr      = `FETCH_BOOT_ADDR - 32'd4;
  logic        req_prev       = 1'b0;
  int unsigned req_count      = 0;
  int unsigned rec_count      = 0;
  int unsigned ack_count      = 0;
  int unsigned cycle_count    = 0;
  logic        ack_allowed    = 1'b0;
  logic        debug_expected = 1'b0;
  logic        in_debug       = 1'b0;
  irq_id_t     exp_irq_id     = '0;

  // Memory responder
  logic [31:0] rng          = 32'd9;
  int unsigned stall_cycles = 0;
  int unsigned gnt_wait     = 0;
  int unsigned rsp_wait     = 0;
  logic        drawn        = 1'b0;
  logic        busy         = 1'b0;
  logic        gnt_nxt      = 1'b0;
  logic        rvalid_nxt   = 1'b0;
  addr_t       rsp_addr     = '0;

  fetch_subsys_top u_dut (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fetch_enable_i  (fetch_enable_i),
    .irq_ext_i       (irq_ext_i),
    .irq_vp_i        (irq_vp_i),
    .debug_req_ext_i (debug_req_ext_i),
    .debug_req_vp_i  (debug_req_vp_i),
    .instr_req_o     (instr_req_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_addr_o    (instr_addr_o),
    .instr_we_o      (instr_we_o),
    .instr_be_o      (instr_be_o),
    .instr_rdata_i   (instr_rdata_i),
    .irq_ack_o       (irq_ack_o),
    .irq_id_o        (irq_id_o),
    .debug_mode_o    (debug_mode_o),
    .trace_o         (trace_o)
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic stop_run();
    $display("Verification failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  //----------------------------------------------------------
  // Compare tasks
  //----------------------------------------------------------

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_irq_id(input irq_id_t got, input irq_id_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_trace(input trace_t got, input trace_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s mismatch", $time, what);
      $display("  got      order %0d addr %h data %h dbg %b",
               got.order, got.addr, got.data, got.dbg);
      $display("  expected order %0d addr %h data %h dbg %b",
               exp.order, exp.addr, exp.data, exp.dbg);
      stop_run();
    end
  endtask

  //----------------------------------------------------------
  // Cycle stepping and scoreboard
  //----------------------------------------------------------

  // Next fetch address by priority debug, interrupt, sequential
  task automatic note_request();
    addr_t  exp_addr;
    trace_t rec;
    if (debug_mode_o && !in_debug) begin
      in_debug = 1'b1;
      exp_addr = `FETCH_DM_HALT_ADDR;
    end else if (irq_ack_o) begin
      check_irq_id(irq_id_o, exp_irq_id, "acknowledged interrupt id");
      exp_addr = `FETCH_MTVEC_BASE + addr_t'(exp_irq_id) * 4;
      ack_count++;
    end else begin
      exp_addr = last_addr + 32'd4;
    end
    check_addr(instr_addr_o, exp_addr, "fetch address");
    last_addr = exp_addr;
    rec       = '0;
    rec.valid = 1'b1;
    rec.order = order_t'(req_count);
    rec.addr  = exp_addr;
    rec.data  = exp_addr ^ DATA_KEY;
    rec.dbg   = in_debug;
    exp_q.push_back(rec);
    req_count++;
  endtask

  // Samples at 1 ns after the edge and returns at 2 ns to drive
  task automatic tick();
    @(posedge clk_i);
    #1;
    if (irq_ack_o && !ack_allowed) begin
      $display("Interrupt acknowledged at %0t while none was expected", $time);
      stop_run();
    end else if (debug_mode_o && !debug_expected) begin
      $display("Debug mode entered at %0t without a debug request", $time);
      stop_run();
    end else if (trace_o.valid && exp_q.size() == 0) begin
      $display("Trace record at %0t without a matching fetch", $time);
      stop_run();
    end else begin
      if (in_debug) begin
        check_flag(debug_mode_o, 1'b1, "debug mode stays set");
      end
      if (instr_req_o && !req_prev) begin
        note_request();
      end
      req_prev = instr_req_o;
      if (trace_o.valid) begin
        check_trace(trace_o, exp_q.pop_front(), "trace record");
        rec_count++;
      end
    end
    #1;
  endtask

  task automatic wait_records(input int unsigned n);
    while (rec_count < n) begin
      tick();
    end
  endtask

  //----------------------------------------------------------
  // OBI memory responder and cycle limit
  //----------------------------------------------------------

  // Grant after 0 to 2 cycles and answer 1 to 3 cycles after grant
  always @(posedge clk_i) begin
    #1;
    gnt_nxt    = 1'b0;
    rvalid_nxt = 1'b0;
    if (!rst_n_i) begin
      busy  = 1'b0;
      drawn = 1'b0;
    end else if (busy) begin
      if (rsp_wait == 0) begin
        rvalid_nxt = 1'b1;
        busy       = 1'b0;
      end else begin
        rsp_wait--;
      end
    end else if (instr_req_o) begin
      if (!drawn) begin
        rng          = xorshift(rng);
        gnt_wait     = (stall_cycles != 0) ? stall_cycles : rng % 3;
        stall_cycles = 0;
        drawn        = 1'b1;
      end
      if (gnt_wait == 0) begin
        rng      = xorshift(rng);
        rsp_wait = rng % 3;
        rsp_addr = instr_addr_o;
        gnt_nxt  = 1'b1;
        busy     = 1'b1;
        drawn    = 1'b0;
      end else begin
        gnt_wait--;
      end
    end
    #1;
    instr_gnt_i    = gnt_nxt;
    instr_rvalid_i = rvalid_nxt;
    instr_rdata_i  = rvalid_nxt ? (rsp_addr ^ DATA_KEY) : '0;
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > MAX_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      stop_run();
    end
  end

  //----------------------------------------------------------
  // Tests
  //----------------------------------------------------------

  task automatic reset_and_disable();
    repeat (10) begin
      tick();
      check_flag(instr_req_o, 1'b0, "request while fetch disabled");
      check_flag(irq_ack_o, 1'b0, "interrupt ack after reset");
      check_flag(debug_mode_o, 1'b0, "debug mode after reset");
      check_flag(trace_o.valid, 1'b0, "trace valid while fetch disabled");
      check_flag(instr_we_o, 1'b0, "write enable tied low");
      check_flag(&instr_be_o, 1'b1, "byte enables all ones");
    end
  endtask

  task automatic sequential_fetch();
    fetch_enable_i = 1'b1;
    tick();
    check_flag(instr_req_o, 1'b1, "request one cycle after enable");
    wait_records(8);
  endtask

  task automatic back_pressure();
    addr_t       held;
    int unsigned start_req;
    int unsigned start_rec;
    stall_cycles = 6;
    start_req    = req_count;
    while (req_count == start_req) begin
      tick();
    end
    held      = instr_addr_o;
    start_rec = rec_count;
    repeat (6) begin
      tick();
      check_flag(instr_req_o, 1'b1, "request held without grant");
      check_addr(instr_addr_o, held, "address held without grant");
      check_flag(rec_count == start_rec, 1'b1, "no trace record before response");
    end
    wait_records(start_rec + 1);
  endtask

  task automatic interrupt_redirect();
    ack_allowed  = 1'b1;
    exp_irq_id   = 5'd3;
    irq_vp_i[5]  = 1'b1;
    irq_ext_i[3] = 1'b1;
    while (ack_count == 0) begin
      tick();
    end
    // Line 3 drops after its ack and line 5 comes next
    irq_ext_i[3] = 1'b0;
    exp_irq_id   = 5'd5;
    while (ack_count == 1) begin
      tick();
    end
    // Line 5 stays up while masked and must not be taken again
    ack_allowed = 1'b0;
    wait_records(req_count + 1);
    irq_vp_i[5] = 1'b0;
  endtask

  task automatic debug_entry();
    int unsigned halt_next;
    debug_expected = 1'b1;
    irq_ext_i[7]   = 1'b1;
    debug_req_vp_i = 1'b1;
    while (!in_debug) begin
      tick();
    end
    // Interrupt line stays up but must not be taken in debug mode
    debug_req_vp_i = 1'b0;
    halt_next      = req_count;
    wait_records(halt_next + 3);
    check_flag(debug_mode_o, 1'b1, "debug mode after halt entry");
    irq_ext_i[7] = 1'b0;
  endtask

  initial begin
    repeat (3) begin
      tick();
    end
    rst_n_i = 1'b1;
    reset_and_disable();
    sequential_fetch();
    back_pressure();
    interrupt_redirect();
    debug_entry();
    $display("Verification passed");
    $finish;
  end

endmodule

// File: verilog/fetch_params.svh
//----------------------------------------------------------
// Fixed fetch addresses for the instruction-fetch subsystem
// Included by the fetch unit and by the testbench
//----------------------------------------------------------

`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

//----------------------------------------------------------
// Reset and trap entry points
//----------------------------------------------------------

// First word fetched once fetch is enabled after reset
`define FETCH_BOOT_ADDR     32'h0000_0800

// Vectored interrupt table, one word per interrupt id
`define FETCH_MTVEC_BASE    32'h0000_0400

//----------------------------------------------------------
// Debug
//----------------------------------------------------------

// Halt entry of the debug module
`define FETCH_DM_HALT_ADDR  32'h1A11_0800

`endif

// File: verilog/fetch_pkg.sv
//----------------------------------------------------------
// Shared types of the fetch subsystem: bus widths, FSM states
// and the trace record emitted on the retire side
//----------------------------------------------------------

package fetch_pkg;

  // Byte address on the instruction bus
  typedef logic [31:0] addr_t;

  // Instruction word as returned on rdata
  typedef logic [31:0] word_t;

  // One bit per interrupt line
  typedef logic [31:0] irq_vec_t;

  // Interrupt number, index into irq_vec_t
  typedef logic [4:0]  irq_id_t;

  // Sequence number of a trace record
  typedef logic [15:0] order_t;

  // Fetch FSM
  // IDLE picks the next address, REQ waits for gnt, WAIT for rvalid
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    REQ  = 2'd1,
    WAIT = 2'd2
  } fetch_state_e;

  // Pads the trace record up to three bus words
  localparam int unsigned TRACE_PAD_W = 14;

  // Retire-style record, one per returned instruction word
  typedef struct packed {
    logic                   valid;
    order_t                 order;
    addr_t                  addr;
    word_t                  data;
    logic                   dbg;
    logic [TRACE_PAD_W-1:0] pad;
  } trace_t;

endpackage

// File: verilog/fetch_retire.sv
//----------------------------------------------------------
// Pairs each OBI response with its granted address and emits
// a numbered trace record one cycle after rvalid
//----------------------------------------------------------

`timescale 1ns/1ps

module fetch_retire import fetch_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   req_i,
  input  logic   gnt_i,
  input  logic   rvalid_i,
  input  addr_t  addr_i,
  input  word_t  rdata_i,
  input  logic   debug_mode_i,
  output trace_t trace_o
);

  logic   accept;
  logic   outstanding_q;
  logic   valid_q;
  order_t order_q;
  addr_t  acc_addr_q;
  logic   acc_dbg_q;
  order_t rec_order_q;
  addr_t  rec_addr_q;
  word_t  rec_data_q;
  logic   rec_dbg_q;

  assign accept = req_i && gnt_i;

  // Control side, outstanding flag and running order count
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      outstanding_q <= 1'b0;
      valid_q       <= 1'b0;
      order_q       <= '0;
    end else begin
      valid_q <= rvalid_i;
      if (accept) begin
        outstanding_q <= 1'b1;
      end else if (rvalid_i) begin
        outstanding_q <= 1'b0;
      end
      if (rvalid_i) begin
        order_q <= order_q + order_t'(1);
      end
    end
  end

  // Address and mode are taken at grant, the rest at the response
  always_ff @(posedge clk_i) begin
    if (accept) begin
      acc_addr_q <= addr_i;
      acc_dbg_q  <= debug_mode_i;
    end
    if (rvalid_i) begin
      rec_order_q <= order_q;
      rec_addr_q  <= acc_addr_q;
      rec_data_q  <= rdata_i;
      rec_dbg_q   <= acc_dbg_q;
    end
  end

  always_comb begin
    trace_o       = '0;
    trace_o.valid = valid_q;
    trace_o.order = rec_order_q;
    trace_o.addr  = rec_addr_q;
    trace_o.data  = rec_data_q;
    trace_o.dbg   = rec_dbg_q;
  end

  // A response needs a granted transfer still open
  a_rvalid_outstanding: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |-> outstanding_q
  );

endmodule

// File: verilog/fetch_subsys_top.sv
//----------------------------------------------------------
// Top of the instruction-fetch subsystem with a read-only OBI
// instruction port, merged interrupt/debug inputs and trace
//----------------------------------------------------------

`timescale 1ns/1ps

module fetch_subsys_top import fetch_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     fetch_enable_i,
  // Interrupt and debug sources
  input  irq_vec_t irq_ext_i,
  input  irq_vec_t irq_vp_i,
  input  logic     debug_req_ext_i,
  input  logic     debug_req_vp_i,
  // OBI instruction port
  output logic     instr_req_o,
  input  logic     instr_gnt_i,
  input  logic     instr_rvalid_i,
  output addr_t    instr_addr_o,
  output logic     instr_we_o,
  output logic [3:0] instr_be_o,
  input  word_t    instr_rdata_i,
  // Status and trace
  output logic     irq_ack_o,
  output irq_id_t  irq_id_o,
  output logic     debug_mode_o,
  output trace_t   trace_o
);

  logic    irq_pending;
  irq_id_t irq_pend_id;
  logic    debug_req;

  // Instruction bus never writes
  assign instr_we_o = 1'b0;
  assign instr_be_o = '1;

  irq_debug_merge u_merge (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .irq_ext_i       (irq_ext_i),
    .irq_vp_i        (irq_vp_i),
    .debug_req_ext_i (debug_req_ext_i),
    .debug_req_vp_i  (debug_req_vp_i),
    .irq_ack_i       (irq_ack_o),
    .irq_id_i        (irq_id_o),
    .irq_pending_o   (irq_pending),
    .irq_id_o        (irq_pend_id),
    .debug_req_o     (debug_req)
  );

  fetch_unit u_fetch (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fetch_enable_i (fetch_enable_i),
    .irq_pending_i  (irq_pending),
    .irq_id_i       (irq_pend_id),
    .debug_req_i    (debug_req),
    .gnt_i          (instr_gnt_i),
    .rvalid_i       (instr_rvalid_i),
    .req_o          (instr_req_o),
    .addr_o         (instr_addr_o),
    .irq_ack_o      (irq_ack_o),
    .irq_id_o       (irq_id_o),
    .debug_mode_o   (debug_mode_o)
  );

  fetch_retire u_retire (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (instr_req_o),
    .gnt_i        (instr_gnt_i),
    .rvalid_i     (instr_rvalid_i),
    .addr_i       (instr_addr_o),
    .rdata_i      (instr_rdata_i),
    .debug_mode_i (debug_mode_o),
    .trace_o      (trace_o)
  );

endmodule

// File: verilog/fetch_unit.sv
//----------------------------------------------------------
// Program counter and OBI request FSM with one transfer at a time
// Redirects to debug halt or interrupt vector from IDLE only
//----------------------------------------------------------

`timescale 1ns/1ps

`include "fetch_params.svh"

module fetch_unit import fetch_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    fetch_enable_i,
  input  logic    irq_pending_i,
  input  irq_id_t irq_id_i,
  input  logic    debug_req_i,
  input  logic    gnt_i,
  input  logic    rvalid_i,
  output logic    req_o,
  output addr_t   addr_o,
  output logic    irq_ack_o,
  output irq_id_t irq_id_o,
  output logic    debug_mode_o
);

  fetch_state_e state_q;
  fetch_state_e state_d;
  addr_t        addr_q;
  addr_t        seq_pc_q;
  addr_t        target;
  logic         launch;
  logic         take_dbg;
  logic         take_irq;
  logic         irq_ack_q;
  irq_id_t      irq_id_q;
  logic         debug_mode_q;

  //----------------------------------------------------------
  // Next address selection
  //----------------------------------------------------------

  // A new fetch starts from IDLE whenever fetch is enabled
  assign launch = (state_q == IDLE) && fetch_enable_i;

  // Debug first and no interrupts once in debug mode
  assign take_dbg = launch && debug_req_i && !debug_mode_q;
  assign take_irq = launch && !take_dbg && irq_pending_i && !debug_mode_q;

  always_comb begin
    if (take_dbg) begin
      target = `FETCH_DM_HALT_ADDR;
    end else if (take_irq) begin
      // Vectored entry with four bytes per id
      target = `FETCH_MTVEC_BASE + {25'b0, irq_id_i, 2'b00};
    end else begin
      target = seq_pc_q;
    end
  end

  //----------------------------------------------------------
  // FSM
  //----------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (launch) begin
          state_d = REQ;
        end
      end
      REQ: begin
        // Held here with the same address until granted
        if (gnt_i) begin
          state_d = WAIT;
        end
      end
      WAIT: begin
        if (rvalid_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= IDLE;
      seq_pc_q     <= `FETCH_BOOT_ADDR;
      irq_ack_q    <= 1'b0;
      irq_id_q     <= '0;
      debug_mode_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      irq_ack_q <= take_irq;
      if (launch) begin
        seq_pc_q <= target + 32'd4;
      end
      if (take_irq) begin
        irq_id_q <= irq_id_i;
      end
      // Sticky until reset
      if (take_dbg) begin
        debug_mode_q <= 1'b1;
      end
    end
  end

  // Address of the fetch in flight
  always_ff @(posedge clk_i) begin
    if (launch) begin
      addr_q <= target;
    end
  end

  assign req_o        = (state_q == REQ);
  assign addr_o       = addr_q;
  assign irq_ack_o    = irq_ack_q;
  assign irq_id_o     = irq_id_q;
  assign debug_mode_o = debug_mode_q;

  //----------------------------------------------------------
  // Checks
  //----------------------------------------------------------

  // Responder answers only the transfer in flight
  a_rvalid_in_wait: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |-> state_q == WAIT
  );

endmodule

// File: verilog/irq_debug_merge.sv
//----------------------------------------------------------
// Merges the two interrupt and debug sources by OR, masks
// acknowledged lines and reports the lowest pending id
//----------------------------------------------------------

`timescale 1ns/1ps

module irq_debug_merge import fetch_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  irq_vec_t irq_ext_i,
  input  irq_vec_t irq_vp_i,
  input  logic     debug_req_ext_i,
  input  logic     debug_req_vp_i,
  input  logic     irq_ack_i,
  input  irq_id_t  irq_id_i,
  output logic     irq_pending_o,
  output irq_id_t  irq_id_o,
  output logic     debug_req_o
);

  irq_vec_t irq_src;
  irq_vec_t irq_q;
  irq_vec_t mask_q;
  irq_vec_t ack_vec;
  irq_vec_t irq_avail;
  logic     debug_q;

  assign irq_src = irq_ext_i | irq_vp_i;

  // One-hot of the line being acknowledged this cycle
  assign ack_vec = irq_ack_i ? (irq_vec_t'(1) << irq_id_i) : '0;

  // Registered sources, the mask drops a bit as soon as its line falls
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      irq_q   <= '0;
      mask_q  <= '0;
      debug_q <= 1'b0;
    end else begin
      irq_q   <= irq_src;
      mask_q  <= (mask_q | ack_vec) & irq_src;
      debug_q <= debug_req_ext_i | debug_req_vp_i;
    end
  end

  assign irq_avail     = irq_q & ~mask_q;
  assign irq_pending_o = |irq_avail;
  assign debug_req_o   = debug_q;

  // Lowest set line wins, so scan from the top down
  always_comb begin
    irq_id_o = '0;
    for (int i = $bits(irq_vec_t) - 1; i >= 0; i--) begin
      if (irq_avail[i]) begin
        irq_id_o = irq_id_t'(i);
      end
    end
  end

  //----------------------------------------------------------
  // Checks
  //----------------------------------------------------------

  // The fetch unit may only acknowledge what was reported pending
  a_ack_after_pending: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    irq_ack_i |-> $past(irq_pending_o)
  );

endmodule
